// File: src.f
hw/corebus_lite_pkg.sv
hw/corebus_cmd_router.sv
hw/corebus_scratch_slave.sv
hw/corebus_dummy_slave.sv
hw/corebus_resp_merger.sv
hw/corebus_lite_fabric.sv
verification/corebus_lite_props.sv
verification/corebus_lite_checker.sv
verification/corebus_lite_tb.sv

// File: Makefile
VERILATOR   ?= verilator
TOP         ?= corebus_lite_tb
FILELIST    ?= src.f
OBJ_DIR     ?= obj_dir
LOG         ?= sim.log
LINT_FLAGS  ?=
BUILD_FLAGS ?= --binary --timing --assert
ERROR_LIMIT ?= 1000
FAIL_MSG    ?= Simulation FAILED
PASS_MSG    ?= Simulation PASSED

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(BUILD_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR) -o V$(TOP)

sim: $(SIM_BIN)
	./$(SIM_BIN) +verilator+error+limit+$(ERROR_LIMIT) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "sim: failure reported in $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "sim: run ended without a verdict"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verification/corebus_lite_tb.sv
// Core bus lite fabric testbench
`timescale 1ns/10ps
module corebus_lite_tb;

  localparam int AW = corebus_lite_pkg::DEF_ADDR_WIDTH;
  localparam int DW = corebus_lite_pkg::DEF_DATA_WIDTH;
  localparam int IW = corebus_lite_pkg::DEF_ID_WIDTH;
  localparam int LW = corebus_lite_pkg::DEF_LEN_WIDTH;
  localparam int SCRATCH_WORDS = corebus_lite_pkg::DEF_SCRATCH_WORDS;
  localparam logic [DW-1:0] ERROR_DATA = corebus_lite_pkg::DEF_ERROR_DATA;
  localparam time CLK_PERIOD = 100;
  localparam time DRIVE_DLY = 10;
  localparam int RESET_CYCLES = 16;
  localparam int DRAIN_CYCLES = 20;
  localparam int NUM_DIRECTED = 27;
  localparam int NUM_RANDOM = 60;
  localparam int NUM_CMDS = NUM_DIRECTED + NUM_RANDOM;
  // Full burst under heavy back-pressure, with margin
  localparam int CMD_BUDGET = 80;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_CMDS * CMD_BUDGET + 4 * DRAIN_CYCLES;
  localparam int unsigned SEED = 97;

  logic                    i_clk;
  logic                    i_rst_n;
  logic                    i_mcmd_valid;
  corebus_lite_pkg::cmd_e  i_mcmd;
  logic [IW-1:0]           i_mid;
  logic [AW-1:0]           i_maddr;
  logic [LW-1:0]           i_mlength;
  logic [DW-1:0]           i_mdata;
  logic                    o_scmd_accept;
  logic                    o_sresp_valid;
  logic                    i_mresp_accept;
  corebus_lite_pkg::resp_e o_sresp;
  logic [IW-1:0]           o_sid;
  logic                    o_serror;
  logic [DW-1:0]           o_sdata;
  logic                    o_sresp_last;

  int unsigned cmd_state = SEED;
  int unsigned bp_state = SEED;
  logic        bp_random = 1'b0;
  logic [DW-1:0] model_mem [SCRATCH_WORDS];
  int          tb_errors = 0;
  int          mismatches;
  int          extra_beats;

  corebus_lite_fabric #(
    .ADDR_WIDTH (AW), .DATA_WIDTH (DW), .ID_WIDTH (IW), .LEN_WIDTH (LW),
    .SCRATCH_WORDS (SCRATCH_WORDS), .ERROR_DATA (ERROR_DATA)
  ) uut (
    .i_clk (i_clk), .i_rst_n (i_rst_n),
    .i_mcmd_valid (i_mcmd_valid), .i_mcmd (i_mcmd), .i_mid (i_mid),
    .i_maddr (i_maddr), .i_mlength (i_mlength), .i_mdata (i_mdata),
    .o_scmd_accept (o_scmd_accept), .o_sresp_valid (o_sresp_valid),
    .i_mresp_accept (i_mresp_accept), .o_sresp (o_sresp), .o_sid (o_sid),
    .o_serror (o_serror), .o_sdata (o_sdata), .o_sresp_last (o_sresp_last)
  );

  corebus_lite_checker #(.ID_WIDTH (IW), .DATA_WIDTH (DW)) u_checker (
    .i_clk (i_clk), .i_rst_n (i_rst_n),
    .i_resp_valid (o_sresp_valid), .i_resp_accept (i_mresp_accept),
    .i_resp (o_sresp), .i_id (o_sid), .i_error (o_serror),
    .i_data (o_sdata), .i_last (o_sresp_last),
    .o_mismatches (mismatches), .o_extra_beats (extra_beats)
  );

  bind corebus_lite_fabric corebus_lite_props #(
    .ID_WIDTH (ID_WIDTH), .DATA_WIDTH (DATA_WIDTH)
  ) u_props (
    .i_clk (i_clk), .i_rst_n (i_rst_n), .i_mcmd_valid (i_mcmd_valid),
    .i_mcmd (i_mcmd), .o_scmd_accept (o_scmd_accept),
    .o_sresp_valid (o_sresp_valid), .i_mresp_accept (i_mresp_accept),
    .o_sresp (o_sresp), .o_sid (o_sid), .o_serror (o_serror),
    .o_sdata (o_sdata), .o_sresp_last (o_sresp_last)
  );

  function automatic int unsigned lcg_next(int unsigned s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Upper state bits, the low ones cycle too quickly
  function automatic logic [15:0] rand16();
    cmd_state = lcg_next(cmd_state);
    return cmd_state[30:15];
  endfunction

  // Expected beats for one command, scratch contents tracked alongside
  function automatic void model_command(corebus_lite_pkg::cmd_e cmd, logic [IW-1:0] id,
                                        logic [AW-1:0] addr, logic [LW-1:0] len,
                                        logic [DW-1:0] data);
    int   beats;
    logic in_scratch;
    in_scratch = int'(addr) < SCRATCH_WORDS;
    beats = (len == '0) ? (1 << LW) : int'(len);
    if (cmd == corebus_lite_pkg::CMD_READ) begin
      for (int i = 0; i < beats; i++) begin
        if (in_scratch) begin
          u_checker.push_expected(corebus_lite_pkg::RESP_WITH_DATA, id, 1'b0,
                                  model_mem[(int'(addr) + i) % SCRATCH_WORDS], i == beats - 1);
        end else begin
          u_checker.push_expected(corebus_lite_pkg::RESP_WITH_DATA, id, 1'b1,
                                  ERROR_DATA, i == beats - 1);
        end
      end
    end else begin
      if (in_scratch) begin
        model_mem[int'(addr)] = data;
      end
      if (cmd == corebus_lite_pkg::CMD_WRITE) begin
        u_checker.push_expected(corebus_lite_pkg::RESP_PLAIN, id, !in_scratch, '0, 1'b1);
      end
    end
  endfunction

  // Entered and left DRIVE_DLY after a rising edge
  task automatic send_cmd(corebus_lite_pkg::cmd_e cmd, logic [IW-1:0] id,
                          logic [AW-1:0] addr, logic [LW-1:0] len, logic [DW-1:0] data);
    logic accepted;
    model_command(cmd, id, addr, len, data);
    i_mcmd_valid = 1'b1;
    i_mcmd       = cmd;
    i_mid        = id;
    i_maddr      = addr;
    i_mlength    = len;
    i_mdata      = data;
    accepted     = 1'b0;
    while (!accepted) begin
      @(negedge i_clk);
      accepted = o_scmd_accept;
      @(posedge i_clk);
      #DRIVE_DLY;
    end
    i_mcmd_valid = 1'b0;
  endtask

  task automatic run_directed();
    for (int i = 0; i < SCRATCH_WORDS; i++) begin
      send_cmd((i < SCRATCH_WORDS / 2) ? corebus_lite_pkg::CMD_WRITE :
               corebus_lite_pkg::CMD_WRITE_POSTED, IW'(i), AW'(i), LW'(1), {rand16(), rand16()});
    end
    send_cmd(corebus_lite_pkg::CMD_READ, 4'h1, 16'd0, 4'd0, '0);
    send_cmd(corebus_lite_pkg::CMD_READ, 4'h2, 16'd12, 4'd8, '0);
    send_cmd(corebus_lite_pkg::CMD_WRITE_POSTED, 4'h3, 16'd3, 4'd1, 32'h1234_5678);
    send_cmd(corebus_lite_pkg::CMD_READ, 4'h4, 16'd3, 4'd1, '0);
    send_cmd(corebus_lite_pkg::CMD_WRITE, 4'h5, 16'd5, 4'd1, 32'hA5A5_0F0F);
    send_cmd(corebus_lite_pkg::CMD_READ, 4'h6, 16'd4, 4'd3, '0);
    // Unmapped space
    send_cmd(corebus_lite_pkg::CMD_READ, 4'h7, 16'h1234, 4'd5, '0);
    send_cmd(corebus_lite_pkg::CMD_READ, 4'h8, 16'h0100, 4'd0, '0);
    send_cmd(corebus_lite_pkg::CMD_WRITE, 4'h9, 16'h8000, 4'd1, 32'h0BAD_F00D);
    send_cmd(corebus_lite_pkg::CMD_WRITE_POSTED, 4'hA, 16'h8001, 4'd1, 32'h0000_0001);
    send_cmd(corebus_lite_pkg::CMD_READ, 4'hB, AW'(SCRATCH_WORDS), 4'd2, '0);
  endtask

  task automatic run_random();
    logic [15:0]            r;
    logic [AW-1:0]          addr;
    corebus_lite_pkg::cmd_e cmd;
    for (int n = 0; n < NUM_RANDOM; n++) begin
      r    = rand16();
      cmd  = corebus_lite_pkg::cmd_e'(2'(r % 3));
      addr = AW'(rand16());
      if (r[8]) begin
        addr = AW'(int'(addr) % SCRATCH_WORDS);
      end else if (int'(addr) < SCRATCH_WORDS) begin
        addr = addr + AW'(SCRATCH_WORDS);
      end
      send_cmd(cmd, IW'(rand16()), addr, LW'(rand16()), {rand16(), rand16()});
    end
  endtask

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  // Response back-pressure, random once enabled
  initial begin
    i_mresp_accept = 1'b0;
    bp_state = lcg_next(bp_state);
    forever begin
      @(posedge i_clk);
      #DRIVE_DLY;
      bp_state = lcg_next(bp_state);
      i_mresp_accept = bp_random ? (bp_state[27] | bp_state[22]) : 1'b1;
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge i_clk);
    $display("Timeout after %0d cycles with %0d response beats still expected",
             WATCHDOG_CYCLES, u_checker.pending_beats());
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    int total;
    i_rst_n      = 1'b0;
    i_mcmd_valid = 1'b0;
    i_mcmd       = corebus_lite_pkg::CMD_READ;
    i_mid        = '0;
    i_maddr      = '0;
    i_mlength    = '0;
    i_mdata      = '0;
    repeat (RESET_CYCLES) @(posedge i_clk);
    #DRIVE_DLY;
    i_rst_n = 1'b1;
    @(posedge i_clk);
    #DRIVE_DLY;
    if (o_sresp_valid !== 1'b0) begin
      $display("mismatch o_sresp_valid: got 0x%0h expected 0x0", o_sresp_valid);
      tb_errors++;
    end
    if (o_scmd_accept !== 1'b1) begin
      $display("mismatch o_scmd_accept: got 0x%0h expected 0x1", o_scmd_accept);
      tb_errors++;
    end
    run_directed();
    bp_random = 1'b1;
    run_random();
    while (u_checker.pending_beats() != 0) begin
      @(posedge i_clk);
    end
    repeat (DRAIN_CYCLES) @(posedge i_clk);
    total = mismatches + extra_beats + tb_errors + uut.u_props.fail_count;
    $display("Errors: mismatches %0d, extra beats %0d, testbench checks %0d, assertions %0d",
             mismatches, extra_beats, tb_errors, uut.u_props.fail_count);
    if (total == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: verification/corebus_lite_checker.sv
// Response channel checker
`timescale 1ns/10ps
module corebus_lite_checker #(
  parameter int ID_WIDTH   = corebus_lite_pkg::DEF_ID_WIDTH,
  parameter int DATA_WIDTH = corebus_lite_pkg::DEF_DATA_WIDTH
) (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  input  logic                    i_resp_valid,
  input  logic                    i_resp_accept,
  input  corebus_lite_pkg::resp_e i_resp,
  input  logic [ID_WIDTH-1:0]     i_id,
  input  logic                    i_error,
  input  logic [DATA_WIDTH-1:0]   i_data,
  input  logic                    i_last,
  output int                      o_mismatches,
  output int                      o_extra_beats
);

  typedef struct packed {
    corebus_lite_pkg::resp_e resp;
    logic [ID_WIDTH-1:0]     id;
    logic                    error;
    logic [DATA_WIDTH-1:0]   data;
    logic                    last;
  } beat_t;

  beat_t exp_q[$];
  beat_t exp_beat;
  int    mismatch_count = 0;
  int    extra_count = 0;

  assign o_mismatches  = mismatch_count;
  assign o_extra_beats = extra_count;

  function automatic void push_expected(corebus_lite_pkg::resp_e resp,
                                        logic [ID_WIDTH-1:0] id, logic error,
                                        logic [DATA_WIDTH-1:0] data, logic last);
    exp_q.push_back({resp, id, error, data, last});
  endfunction

  function automatic int pending_beats();
    return exp_q.size();
  endfunction

  function automatic void check_field(string name, logic [DATA_WIDTH-1:0] got,
                                      logic [DATA_WIDTH-1:0] want);
    if (got !== want) begin
      $display("mismatch %s: got 0x%0h expected 0x%0h at %0t", name, got, want, $time);
      mismatch_count++;
    end
  endfunction

  // Compare on every transferred beat
  always @(posedge i_clk) begin
    if (i_rst_n && i_resp_valid && i_resp_accept) begin
      if (exp_q.size() == 0) begin
        $display("Extra response beat with ID 0x%0h arrived with nothing expected at %0t",
                 i_id, $time);
        extra_count++;
      end else begin
        exp_beat = exp_q.pop_front();
        check_field("o_sresp", DATA_WIDTH'(i_resp), DATA_WIDTH'(exp_beat.resp));
        check_field("o_sid", DATA_WIDTH'(i_id), DATA_WIDTH'(exp_beat.id));
        check_field("o_serror", DATA_WIDTH'(i_error), DATA_WIDTH'(exp_beat.error));
        check_field("o_sresp_last", DATA_WIDTH'(i_last), DATA_WIDTH'(exp_beat.last));
        // Plain beats carry no data
        if (exp_beat.resp == corebus_lite_pkg::RESP_WITH_DATA) begin
          check_field("o_sdata", i_data, exp_beat.data);
        end
      end
    end
  end

endmodule

// File: verification/corebus_lite_props.sv
// Fabric handshake assertions
`timescale 1ns/10ps
module corebus_lite_props #(
  parameter int ID_WIDTH   = corebus_lite_pkg::DEF_ID_WIDTH,
  parameter int DATA_WIDTH = corebus_lite_pkg::DEF_DATA_WIDTH
) (
  input logic                    i_clk,
  input logic                    i_rst_n,
  input logic                    i_mcmd_valid,
  input corebus_lite_pkg::cmd_e  i_mcmd,
  input logic                    o_scmd_accept,
  input logic                    o_sresp_valid,
  input logic                    i_mresp_accept,
  input corebus_lite_pkg::resp_e o_sresp,
  input logic [ID_WIDTH-1:0]     o_sid,
  input logic                    o_serror,
  input logic [DATA_WIDTH-1:0]   o_sdata,
  input logic                    o_sresp_last
);

  int   fail_count = 0;
  logic busy;

  // Non-posted command in flight until its last beat leaves
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      busy <= 1'b0;
    end else if (o_sresp_valid && i_mresp_accept && o_sresp_last) begin
      busy <= 1'b0;
    end else if (i_mcmd_valid && o_scmd_accept &&
                 i_mcmd != corebus_lite_pkg::CMD_WRITE_POSTED) begin
      busy <= 1'b1;
    end
  end

  a_beat_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_sresp_valid && !i_mresp_accept |=> o_sresp_valid && $stable(o_sresp) &&
      $stable(o_sid) && $stable(o_serror) && $stable(o_sdata) && $stable(o_sresp_last))
    else begin
      fail_count = fail_count + 1;
      $error("response beat changed while it was waiting for accept");
    end

  a_one_outstanding: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    busy |-> !o_scmd_accept)
    else begin
      fail_count = fail_count + 1;
      $error("command accepted while a non-posted response was outstanding");
    end

  a_quiet_in_reset: assert property (@(posedge i_clk) !i_rst_n |-> !o_sresp_valid)
    else begin
      fail_count = fail_count + 1;
      $error("response valid seen during reset");
    end

endmodule

// File: hw/corebus_lite_fabric.sv
// Core bus lite fabric top level
`timescale 1ns/10ps
module corebus_lite_fabric #(
  parameter int          ADDR_WIDTH    = corebus_lite_pkg::DEF_ADDR_WIDTH,
  parameter int          DATA_WIDTH    = corebus_lite_pkg::DEF_DATA_WIDTH,
  parameter int          ID_WIDTH      = corebus_lite_pkg::DEF_ID_WIDTH,
  parameter int          LEN_WIDTH     = corebus_lite_pkg::DEF_LEN_WIDTH,
  parameter int          SCRATCH_WORDS = corebus_lite_pkg::DEF_SCRATCH_WORDS,
  parameter logic [31:0] ERROR_DATA    = corebus_lite_pkg::DEF_ERROR_DATA
) (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  input  logic                    i_mcmd_valid,
  input  corebus_lite_pkg::cmd_e  i_mcmd,
  input  logic [ID_WIDTH-1:0]     i_mid,
  input  logic [ADDR_WIDTH-1:0]   i_maddr,
  input  logic [LEN_WIDTH-1:0]    i_mlength,
  input  logic [DATA_WIDTH-1:0]   i_mdata,
  output logic                    o_scmd_accept,
  output logic                    o_sresp_valid,
  input  logic                    i_mresp_accept,
  output corebus_lite_pkg::resp_e o_sresp,
  output logic [ID_WIDTH-1:0]     o_sid,
  output logic                    o_serror,
  output logic [DATA_WIDTH-1:0]   o_sdata,
  output logic                    o_sresp_last
);

  logic                    scratch_cmd_valid;
  logic                    scratch_cmd_accept;
  logic                    dummy_cmd_valid;
  logic                    dummy_cmd_accept;
  logic                    resp_done;

  logic                    scratch_resp_valid;
  logic                    scratch_resp_accept;
  corebus_lite_pkg::resp_e scratch_resp;
  logic [ID_WIDTH-1:0]     scratch_id;
  logic [DATA_WIDTH-1:0]   scratch_data;
  logic                    scratch_last;

  logic                    dummy_resp_valid;
  logic                    dummy_resp_accept;
  corebus_lite_pkg::resp_e dummy_resp;
  logic [ID_WIDTH-1:0]     dummy_id;
  logic                    dummy_error;
  logic [DATA_WIDTH-1:0]   dummy_data;
  logic                    dummy_last;

  corebus_cmd_router #(
    .ADDR_WIDTH    (ADDR_WIDTH),
    .SCRATCH_WORDS (SCRATCH_WORDS)
  ) u_router (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_mcmd_valid     (i_mcmd_valid),
    .i_maddr          (i_maddr),
    .i_mcmd           (i_mcmd),
    .o_scmd_accept    (o_scmd_accept),
    .o_scratch_valid  (scratch_cmd_valid),
    .i_scratch_accept (scratch_cmd_accept),
    .o_dummy_valid    (dummy_cmd_valid),
    .i_dummy_accept   (dummy_cmd_accept),
    .i_resp_done      (resp_done)
  );

  corebus_scratch_slave #(
    .ADDR_WIDTH    (ADDR_WIDTH),
    .DATA_WIDTH    (DATA_WIDTH),
    .ID_WIDTH      (ID_WIDTH),
    .LEN_WIDTH     (LEN_WIDTH),
    .SCRATCH_WORDS (SCRATCH_WORDS)
  ) u_scratch (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_cmd_valid   (scratch_cmd_valid),
    .o_cmd_accept  (scratch_cmd_accept),
    .i_cmd         (i_mcmd),
    .i_id          (i_mid),
    .i_addr        (i_maddr),
    .i_length      (i_mlength),
    .i_wdata       (i_mdata),
    .o_resp_valid  (scratch_resp_valid),
    .i_resp_accept (scratch_resp_accept),
    .o_resp        (scratch_resp),
    .o_id          (scratch_id),
    .o_data        (scratch_data),
    .o_last        (scratch_last)
  );

  corebus_dummy_slave #(
    .DATA_WIDTH (DATA_WIDTH),
    .ID_WIDTH   (ID_WIDTH),
    .LEN_WIDTH  (LEN_WIDTH),
    .ERROR_DATA (ERROR_DATA)
  ) u_dummy (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_cmd_valid   (dummy_cmd_valid),
    .o_cmd_accept  (dummy_cmd_accept),
    .i_cmd         (i_mcmd),
    .i_id          (i_mid),
    .i_length      (i_mlength),
    .o_resp_valid  (dummy_resp_valid),
    .i_resp_accept (dummy_resp_accept),
    .o_resp        (dummy_resp),
    .o_id          (dummy_id),
    .o_error       (dummy_error),
    .o_data        (dummy_data),
    .o_last        (dummy_last)
  );

  corebus_resp_merger #(
    .DATA_WIDTH (DATA_WIDTH),
    .ID_WIDTH   (ID_WIDTH)
  ) u_merger (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_scratch_valid  (scratch_resp_valid),
    .o_scratch_accept (scratch_resp_accept),
    .i_scratch_resp   (scratch_resp),
    .i_scratch_id     (scratch_id),
    .i_scratch_data   (scratch_data),
    .i_scratch_last   (scratch_last),
    .i_dummy_valid    (dummy_resp_valid),
    .o_dummy_accept   (dummy_resp_accept),
    .i_dummy_resp     (dummy_resp),
    .i_dummy_id       (dummy_id),
    .i_dummy_error    (dummy_error),
    .i_dummy_data     (dummy_data),
    .i_dummy_last     (dummy_last),
    .o_sresp_valid    (o_sresp_valid),
    .i_mresp_accept   (i_mresp_accept),
    .o_sresp          (o_sresp),
    .o_sid            (o_sid),
    .o_serror         (o_serror),
    .o_sdata          (o_sdata),
    .o_sresp_last     (o_sresp_last),
    .o_resp_done      (resp_done)
  );

endmodule

// File: hw/corebus_resp_merger.sv
// Response merger with one output register
`timescale 1ns/10ps
module corebus_resp_merger #(
  parameter int DATA_WIDTH = corebus_lite_pkg::DEF_DATA_WIDTH,
  parameter int ID_WIDTH   = corebus_lite_pkg::DEF_ID_WIDTH
) (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  input  logic                    i_scratch_valid,
  output logic                    o_scratch_accept,
  input  corebus_lite_pkg::resp_e i_scratch_resp,
  input  logic [ID_WIDTH-1:0]     i_scratch_id,
  input  logic [DATA_WIDTH-1:0]   i_scratch_data,
  input  logic                    i_scratch_last,
  input  logic                    i_dummy_valid,
  output logic                    o_dummy_accept,
  input  corebus_lite_pkg::resp_e i_dummy_resp,
  input  logic [ID_WIDTH-1:0]     i_dummy_id,
  input  logic                    i_dummy_error,
  input  logic [DATA_WIDTH-1:0]   i_dummy_data,
  input  logic                    i_dummy_last,
  output logic                    o_sresp_valid,
  input  logic                    i_mresp_accept,
  output corebus_lite_pkg::resp_e o_sresp,
  output logic [ID_WIDTH-1:0]     o_sid,
  output logic                    o_serror,
  output logic [DATA_WIDTH-1:0]   o_sdata,
  output logic                    o_sresp_last,
  output logic                    o_resp_done
);

  logic take;
  logic can_load;
  logic load_scratch;
  logic load_dummy;

  always_comb begin
    take             = o_sresp_valid && i_mresp_accept;
    can_load         = !o_sresp_valid || take;
    // Scratch wins when both slaves offer a beat
    o_scratch_accept = can_load;
    o_dummy_accept   = can_load && !i_scratch_valid;
    load_scratch     = i_scratch_valid && o_scratch_accept;
    load_dummy       = i_dummy_valid && o_dummy_accept;
    o_resp_done      = take && o_sresp_last;
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_sresp_valid <= 1'b0;
    end else if (load_scratch || load_dummy) begin
      o_sresp_valid <= 1'b1;
    end else if (take) begin
      o_sresp_valid <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (load_scratch) begin
      o_sresp      <= i_scratch_resp;
      o_sid        <= i_scratch_id;
      o_serror     <= 1'b0;
      o_sdata      <= i_scratch_data;
      o_sresp_last <= i_scratch_last;
    end else if (load_dummy) begin
      o_sresp      <= i_dummy_resp;
      o_sid        <= i_dummy_id;
      o_serror     <= i_dummy_error;
      o_sdata      <= i_dummy_data;
      o_sresp_last <= i_dummy_last;
    end
  end

endmodule

// File: hw/corebus_dummy_slave.sv
// Unmapped region slave
`timescale 1ns/10ps
module corebus_dummy_slave #(
  parameter int          DATA_WIDTH = corebus_lite_pkg::DEF_DATA_WIDTH,
  parameter int          ID_WIDTH   = corebus_lite_pkg::DEF_ID_WIDTH,
  parameter int          LEN_WIDTH  = corebus_lite_pkg::DEF_LEN_WIDTH,
  parameter logic [31:0] ERROR_DATA = corebus_lite_pkg::DEF_ERROR_DATA
) (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  input  logic                    i_cmd_valid,
  output logic                    o_cmd_accept,
  input  corebus_lite_pkg::cmd_e  i_cmd,
  input  logic [ID_WIDTH-1:0]     i_id,
  input  logic [LEN_WIDTH-1:0]    i_length,
  output logic                    o_resp_valid,
  input  logic                    i_resp_accept,
  output corebus_lite_pkg::resp_e o_resp,
  output logic [ID_WIDTH-1:0]     o_id,
  output logic                    o_error,
  output logic [DATA_WIDTH-1:0]   o_data,
  output logic                    o_last
);

  // Error word repeated across the data bus
  localparam logic [DATA_WIDTH-1:0] READ_DATA = {(DATA_WIDTH / 32){ERROR_DATA}};

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_PREP,
    ST_RESP
  } state_e;

  state_e             state;
  logic [LEN_WIDTH:0] beats_left;
  logic [LEN_WIDTH:0] len_beats;
  logic               cmd_fire;
  logic               resp_fire;
  logic               non_posted;

  assign o_cmd_accept = state == ST_IDLE;
  assign o_resp_valid = state == ST_RESP;
  assign o_last       = beats_left == (LEN_WIDTH+1)'(1);
  assign o_data       = READ_DATA;
  assign o_error      = 1'b1;

  always_comb begin
    cmd_fire   = i_cmd_valid && o_cmd_accept;
    resp_fire  = o_resp_valid && i_resp_accept;
    non_posted = i_cmd != corebus_lite_pkg::CMD_WRITE_POSTED;
    len_beats  = (i_length == '0) ? {1'b1, {LEN_WIDTH{1'b0}}} : {1'b0, i_length};
  end

  always_ff @(posedge i_clk) begin
    if (cmd_fire && non_posted) begin
      o_id   <= i_id;
      o_resp <= get_resp(i_cmd);
    end
  end

  // Posted writes are swallowed in idle
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: if (cmd_fire && non_posted) state <= ST_PREP;
        ST_PREP: state <= ST_RESP;
        ST_RESP: if (resp_fire && o_last) state <= ST_IDLE;
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      beats_left <= '0;
    end else if (cmd_fire) begin
      if (i_cmd == corebus_lite_pkg::CMD_READ) begin
        beats_left <= len_beats;
      end else begin
        beats_left <= (LEN_WIDTH+1)'(1);
      end
    end else if (resp_fire) begin
      beats_left <= beats_left - (LEN_WIDTH+1)'(1);
    end
  end

  // Reads carry data, everything else is a plain response
  function automatic corebus_lite_pkg::resp_e get_resp(corebus_lite_pkg::cmd_e cmd);
    if (cmd == corebus_lite_pkg::CMD_READ) begin
      return corebus_lite_pkg::RESP_WITH_DATA;
    end
    return corebus_lite_pkg::RESP_PLAIN;
  endfunction

endmodule

// File: hw/corebus_scratch_slave.sv
// Scratch memory slave
`timescale 1ns/10ps
module corebus_scratch_slave #(
  parameter int ADDR_WIDTH    = corebus_lite_pkg::DEF_ADDR_WIDTH,
  parameter int DATA_WIDTH    = corebus_lite_pkg::DEF_DATA_WIDTH,
  parameter int ID_WIDTH      = corebus_lite_pkg::DEF_ID_WIDTH,
  parameter int LEN_WIDTH     = corebus_lite_pkg::DEF_LEN_WIDTH,
  parameter int SCRATCH_WORDS = corebus_lite_pkg::DEF_SCRATCH_WORDS
) (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  input  logic                    i_cmd_valid,
  output logic                    o_cmd_accept,
  input  corebus_lite_pkg::cmd_e  i_cmd,
  input  logic [ID_WIDTH-1:0]     i_id,
  input  logic [ADDR_WIDTH-1:0]   i_addr,
  input  logic [LEN_WIDTH-1:0]    i_length,
  input  logic [DATA_WIDTH-1:0]   i_wdata,
  output logic                    o_resp_valid,
  input  logic                    i_resp_accept,
  output corebus_lite_pkg::resp_e o_resp,
  output logic [ID_WIDTH-1:0]     o_id,
  output logic [DATA_WIDTH-1:0]   o_data,
  output logic                    o_last
);

  localparam int IDX_W = (SCRATCH_WORDS > 1) ? $clog2(SCRATCH_WORDS) : 1;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_PREP,
    ST_RESP
  } state_e;

  state_e                  state;
  logic [DATA_WIDTH-1:0]   mem [SCRATCH_WORDS];
  logic [IDX_W-1:0]        ptr;
  logic [IDX_W-1:0]        cmd_idx;
  logic [LEN_WIDTH:0]      beats_left;
  logic [LEN_WIDTH:0]      len_beats;
  logic                    cmd_fire;
  logic                    resp_fire;
  logic                    is_read;

  assign o_cmd_accept = state == ST_IDLE;
  assign o_resp_valid = state == ST_RESP;
  assign o_last       = beats_left == (LEN_WIDTH+1)'(1);
  assign o_data       = mem[ptr];

  always_comb begin
    cmd_fire  = i_cmd_valid && o_cmd_accept;
    resp_fire = o_resp_valid && i_resp_accept;
    is_read   = i_cmd == corebus_lite_pkg::CMD_READ;
    cmd_idx   = IDX_W'(i_addr);
    // Zero length means a full burst
    len_beats = (i_length == '0) ? {1'b1, {LEN_WIDTH{1'b0}}} : {1'b0, i_length};
  end

  // Both write kinds land in memory on the command edge
  always_ff @(posedge i_clk) begin
    if (cmd_fire && !is_read) begin
      mem[cmd_idx] <= i_wdata;
    end
  end

  always_ff @(posedge i_clk) begin
    if (cmd_fire) begin
      o_id   <= i_id;
      o_resp <= is_read ? corebus_lite_pkg::RESP_WITH_DATA : corebus_lite_pkg::RESP_PLAIN;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: if (cmd_fire && i_cmd != corebus_lite_pkg::CMD_WRITE_POSTED) state <= ST_PREP;
        ST_PREP: state <= ST_RESP;
        ST_RESP: if (resp_fire && o_last) state <= ST_IDLE;
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Beat counter and word pointer, wrapping inside the scratch
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      beats_left <= '0;
      ptr        <= '0;
    end else if (cmd_fire) begin
      beats_left <= is_read ? len_beats : (LEN_WIDTH+1)'(1);
      ptr        <= cmd_idx;
    end else if (resp_fire) begin
      beats_left <= beats_left - (LEN_WIDTH+1)'(1);
      ptr        <= (ptr == IDX_W'(SCRATCH_WORDS - 1)) ? '0 : ptr + IDX_W'(1);
    end
  end

endmodule

// File: hw/corebus_cmd_router.sv
// Core bus command router
`timescale 1ns/10ps
module corebus_cmd_router #(
  parameter int ADDR_WIDTH    = corebus_lite_pkg::DEF_ADDR_WIDTH,
  parameter int SCRATCH_WORDS = corebus_lite_pkg::DEF_SCRATCH_WORDS
) (
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  input  logic                   i_mcmd_valid,
  input  logic [ADDR_WIDTH-1:0]  i_maddr,
  input  corebus_lite_pkg::cmd_e i_mcmd,
  output logic                   o_scmd_accept,
  output logic                   o_scratch_valid,
  input  logic                   i_scratch_accept,
  output logic                   o_dummy_valid,
  input  logic                   i_dummy_accept,
  input  logic                   i_resp_done
);

  localparam logic [ADDR_WIDTH-1:0] SCRATCH_LIMIT = ADDR_WIDTH'(SCRATCH_WORDS);

  logic sel_scratch;
  logic lock;
  logic cmd_fire;
  logic non_posted;

  // Address decode
  always_comb begin
    sel_scratch = i_maddr < SCRATCH_LIMIT;
    non_posted  = i_mcmd != corebus_lite_pkg::CMD_WRITE_POSTED;
  end

  // Steering, nothing reaches a slave while a response is outstanding
  always_comb begin
    o_scratch_valid = i_mcmd_valid && sel_scratch && !lock;
    o_dummy_valid   = i_mcmd_valid && !sel_scratch && !lock;
  end

  always_comb begin
    if (lock) begin
      o_scmd_accept = 1'b0;
    end else if (sel_scratch) begin
      o_scmd_accept = i_scratch_accept;
    end else begin
      o_scmd_accept = i_dummy_accept;
    end
  end

  assign cmd_fire = i_mcmd_valid && o_scmd_accept;

  // Outstanding lock, held until the last response beat leaves the fabric
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      lock <= 1'b0;
    end else if (i_resp_done) begin
      lock <= 1'b0;
    end else if (cmd_fire && non_posted) begin
      lock <= 1'b1;
    end
  end

endmodule

// File: hw/corebus_lite_pkg.sv
// Core bus lite shared definitions
package corebus_lite_pkg;

  // Command opcodes
  typedef enum logic [1:0] {
    CMD_READ         = 2'd0,
    CMD_WRITE        = 2'd1,
    CMD_WRITE_POSTED = 2'd2
  } cmd_e;

  // Response kinds
  typedef enum logic {
    RESP_PLAIN     = 1'b0,
    RESP_WITH_DATA = 1'b1
  } resp_e;

  // Default bus widths
  localparam int DEF_ADDR_WIDTH = 16;
  localparam int DEF_DATA_WIDTH = 32;
  localparam int DEF_ID_WIDTH   = 4;

  // Zero in the burst length field encodes 2**LEN_WIDTH beats
  localparam int DEF_LEN_WIDTH = 4;

  // Words below this address go to the scratch memory
  localparam int DEF_SCRATCH_WORDS = 16;

  // Read data returned from unmapped space
  localparam logic [31:0] DEF_ERROR_DATA = 32'hDEAD_C0DE;

endpackage
